// ==== src.f ====
src/pf_checker_pkg.sv
src/rx_st_if.sv
src/tlp_route_decode.sv
src/rx_st_egress_reg.sv
src/pf_checker_top.sv
testbench/pf_checker_props.sv
testbench/tb_pf_checker.sv

// ==== run.sh ====
#!/bin/sh
# build the router testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f src.f --top-module tb_pf_checker -o sim_pf_checker &&
./obj_dir/sim_pf_checker | tee /dev/stderr | grep -Fqx '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== testbench/tb_pf_checker.sv ====
// ---------------------------------------------------------------------------
// testbench for the PF checker router
// LCG stimulus, reference routing function, per-cycle egress compare
// and per-test reporting
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_pf_checker;

	// one beat in egress port order
	typedef struct packed {
		logic                       sop;
		logic                       eop;
		logic                       hvalid;
		logic                       dvalid;
		pf_checker_pkg::bar_t       bar;
		pf_checker_pkg::hdr_t       header;
		pf_checker_pkg::payload_t   payload;
		pf_checker_pkg::empty_t     empty;
		pf_checker_pkg::pfnum_t     pfnum;
		logic                       passthrough;
	} fields_t;

	typedef struct packed {
		fields_t                 f;
		pf_checker_pkg::dest_t   dest;
		logic [31:0]             cyc;
	} expect_t;

	logic                       clk;
	logic                       arst_n_i;
	logic                       rx_sop_i, rx_eop_i, rx_hvalid_i, rx_dvalid_i;
	logic                       rx_passthrough_i;
	pf_checker_pkg::bar_t       rx_bar_i;
	pf_checker_pkg::hdr_t       rx_header_i;
	pf_checker_pkg::payload_t   rx_payload_i;
	pf_checker_pkg::empty_t     rx_empty_i;
	pf_checker_pkg::pfnum_t     rx_pfnum_i;
	logic                       rx_ready_o;
	logic                       sel_afu_i, pf0_mem_en_i, pf1_mem_en_i;
	logic                       pio_ready_i, def_ready_i;

	// egress outputs
	logic pio_sop_o, pio_eop_o, pio_hvalid_o, pio_dvalid_o, pio_passthrough_o;
	logic afu_sop_o, afu_eop_o, afu_hvalid_o, afu_dvalid_o, afu_passthrough_o;
	logic def_sop_o, def_eop_o, def_hvalid_o, def_dvalid_o, def_passthrough_o;
	pf_checker_pkg::bar_t       pio_bar_o, afu_bar_o, def_bar_o;
	pf_checker_pkg::hdr_t       pio_header_o, afu_header_o, def_header_o;
	pf_checker_pkg::payload_t   pio_payload_o, afu_payload_o, def_payload_o;
	pf_checker_pkg::empty_t     pio_empty_o, afu_empty_o, def_empty_o;
	pf_checker_pkg::pfnum_t     pio_pfnum_o, afu_pfnum_o, def_pfnum_o;

	logic [31:0] lcg_state;
	logic [31:0] cyc_cnt;
	expect_t     exp_q[$];
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          err_at_start;
	string       test_name;

	pf_checker_top u_dut (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc_cnt <= cyc_cnt + 32'd1;

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// completions weigh the most, then memory requests, then anything
	function automatic logic [7:0] pick_fmt_type();
		logic [31:0] r;
		r = rand32();
		case (r[31:29])
			3'd0, 3'd1: return 8'h0A;
			3'd2:       return 8'h4A;
			3'd3:       return r[28] ? 8'h20 : 8'h00;
			3'd4:       return r[28] ? 8'h60 : 8'h40;
			default:    return r[15:8];
		endcase
	endfunction

	// config, IO and message types, neither memory nor completion
	function automatic logic [7:0] pick_other_type();
		logic [31:0] r;
		r = rand32();
		case (r[31:29])
			3'd0:    return 8'h04;
			3'd1:    return 8'h44;
			3'd2:    return 8'h30;
			3'd3:    return 8'h72;
			default: return 8'h02;
		endcase
	endfunction

	// expected egress of one beat
	function automatic pf_checker_pkg::dest_t route_ref(input pf_checker_pkg::hdr_t hdr,
		input logic pt, input logic sel, input logic pf0, input logic pf1);
		logic [7:0] ft;
		logic       cpl;
		logic       mem;
		ft  = hdr[31:24];
		cpl = (ft == 8'h0A) || (ft == 8'h4A);
		// type 0 with fmt 000 to 011 covers memory reads and writes
		mem = (ft[4:0] == 5'd0) && !ft[7];
		if (!pt && !sel && pf1)
			return pf_checker_pkg::DEST_PIO;
		if (cpl && sel && pf0)
			return pf_checker_pkg::DEST_AFU;
		if ((pt && !(cpl && sel)) || (sel && mem) || (sel && !pf0) || (!sel && !pf1))
			return pf_checker_pkg::DEST_DEF;
		return pf_checker_pkg::DEST_NONE;
	endfunction

	task automatic send_beat(input logic [7:0] ft, input logic pt, input logic sel,
		input logic pf0, input logic pf1);
		logic [31:0] r;
		expect_t     e;
		@(posedge clk);
		#1;
		r = rand32();
		rx_sop_i    = r[16];
		rx_eop_i    = r[17];
		rx_hvalid_i = r[18];
		rx_dvalid_i = r[19];
		rx_bar_i    = r[22:20];
		rx_empty_i  = r[26:24];
		rx_pfnum_i  = r[29:28];
		rx_header_i = {rand32(), rand32(), rand32(), rand32()};
		rx_header_i[31:24] = ft;
		for (int i = 0; i < 8; i++)
			rx_payload_i[i*32 +: 32] = rand32();
		rx_passthrough_i = pt;
		sel_afu_i        = sel;
		pf0_mem_en_i     = pf0;
		pf1_mem_en_i     = pf1;
		e.f = {rx_sop_i, rx_eop_i, rx_hvalid_i, rx_dvalid_i, rx_bar_i, rx_header_i,
			rx_payload_i, rx_empty_i, rx_pfnum_i, rx_passthrough_i};
		e.dest = route_ref(rx_header_i, pt, sel, pf0, pf1);
		e.cyc  = cyc_cnt;
		exp_q.push_back(e);
	endtask

	// ------------------------------------------------------------------------
	// checking and reporting
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_port(input string pfx, input fields_t got, input fields_t exp);
		check_value({pfx, "_sop_o"}, 256'(got.sop), 256'(exp.sop));
		check_value({pfx, "_eop_o"}, 256'(got.eop), 256'(exp.eop));
		check_value({pfx, "_hvalid_o"}, 256'(got.hvalid), 256'(exp.hvalid));
		check_value({pfx, "_dvalid_o"}, 256'(got.dvalid), 256'(exp.dvalid));
		check_value({pfx, "_bar_o"}, 256'(got.bar), 256'(exp.bar));
		check_value({pfx, "_header_o"}, 256'(got.header), 256'(exp.header));
		check_value({pfx, "_payload_o"}, 256'(got.payload), 256'(exp.payload));
		check_value({pfx, "_empty_o"}, 256'(got.empty), 256'(exp.empty));
		check_value({pfx, "_pfnum_o"}, 256'(got.pfnum), 256'(exp.pfnum));
		check_value({pfx, "_passthrough_o"}, 256'(got.passthrough), 256'(exp.passthrough));
	endtask

	// the chosen egress carries the beat, the other two are all zero
	task automatic compare_egress(input expect_t e);
		fields_t pio_exp;
		fields_t afu_exp;
		fields_t def_exp;
		pio_exp = (e.dest == pf_checker_pkg::DEST_PIO) ? e.f : '0;
		afu_exp = (e.dest == pf_checker_pkg::DEST_AFU) ? e.f : '0;
		def_exp = (e.dest == pf_checker_pkg::DEST_DEF) ? e.f : '0;
		check_port("pio", {pio_sop_o, pio_eop_o, pio_hvalid_o, pio_dvalid_o, pio_bar_o,
			pio_header_o, pio_payload_o, pio_empty_o, pio_pfnum_o, pio_passthrough_o}, pio_exp);
		check_port("afu", {afu_sop_o, afu_eop_o, afu_hvalid_o, afu_dvalid_o, afu_bar_o,
			afu_header_o, afu_payload_o, afu_empty_o, afu_pfnum_o, afu_passthrough_o}, afu_exp);
		check_port("def", {def_sop_o, def_eop_o, def_hvalid_o, def_dvalid_o, def_bar_o,
			def_header_o, def_payload_o, def_empty_o, def_pfnum_o, def_passthrough_o}, def_exp);
	endtask

	// a beat driven in cycle k is registered at the next edge, sample mid-cycle
	always @(negedge clk)
	begin : compare_beats
		expect_t e;
		while (exp_q.size() > 0 && exp_q[0].cyc < cyc_cnt)
		begin
			e = exp_q.pop_front();
			compare_egress(e);
		end
	end

	task automatic begin_test(input string name);
		test_name    = name;
		err_at_start = errors;
	endtask

	task automatic end_test();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 8)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() > 0)
		begin
			$display("timeout: %0d routed beats were never compared", exp_q.size());
			errors++;
			exp_q.delete();
		end
		tests_run++;
		if (errors == err_at_start)
			$display("test %0d %s: passed", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, test_name,
				errors - err_at_start);
		end
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial
	begin : run_tests
		logic [31:0] r;
		clk              = 1'b0;
		arst_n_i         = 1'b0;
		// a valid beat routed to PIO sits on the ingress while reset is held
		rx_sop_i         = 1'b1;
		rx_eop_i         = 1'b1;
		rx_hvalid_i      = 1'b1;
		rx_dvalid_i      = 1'b1;
		rx_bar_i         = 3'd5;
		rx_header_i      = {4{32'h4a5a_c3e1}};
		rx_payload_i     = {8{32'h5a5a_a5a5}};
		rx_empty_i       = 3'd3;
		rx_pfnum_i       = 2'd1;
		rx_passthrough_i = 1'b0;
		sel_afu_i        = 1'b0;
		pf0_mem_en_i     = 1'b1;
		pf1_mem_en_i     = 1'b1;
		pio_ready_i      = 1'b1;
		def_ready_i      = 1'b1;
		lcg_state        = 32'h7e73_a149;
		cyc_cnt          = '0;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		repeat (5) @(posedge clk);
		#1;
		arst_n_i = 1'b1;

		begin_test("reset");
		@(negedge clk);
		compare_egress('0);
		end_test();

		begin_test("pio routing");
		repeat (40)
		begin
			r = rand32();
			send_beat(pick_fmt_type(), 1'b0, 1'b0, r[20], 1'b1);
		end
		end_test();

		begin_test("afu routing");
		repeat (40)
		begin
			r = rand32();
			send_beat(r[21] ? 8'h4A : 8'h0A, r[22], 1'b1, 1'b1, r[20]);
		end
		end_test();

		// passthrough, memory requests with sel high, then disabled PFs
		begin_test("default routing");
		repeat (20)
		begin
			r = rand32();
			send_beat(pick_fmt_type(), 1'b1, 1'b0, r[20], r[21]);
		end
		repeat (20)
		begin
			r = rand32();
			send_beat(r[22] ? 8'h40 : 8'h20, 1'b0, 1'b1, 1'b1, r[21]);
		end
		repeat (20)
		begin
			r = rand32();
			send_beat(pick_fmt_type(), 1'b0, r[23], r[23] ? 1'b0 : r[20],
				r[23] ? r[21] : 1'b0);
		end
		end_test();

		begin_test("discard");
		repeat (30)
		begin
			r = rand32();
			send_beat(pick_other_type(), 1'b0, 1'b1, 1'b1, r[20]);
		end
		end_test();

		begin_test("ready sweep and random routing");
		repeat (300)
		begin
			r = rand32();
			send_beat(pick_fmt_type(), r[16], r[17], r[18], r[19]);
			pio_ready_i = r[20];
			def_ready_i = r[21];
			@(negedge clk);
			check_value("rx_ready_o", 256'(rx_ready_o), 256'(r[20] & r[21]));
		end
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== testbench/pf_checker_props.sv ====
// ---------------------------------------------------------------------------
// concurrent checks on the PF checker top level
// one egress at most, ready AND, idle egresses right after reset
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module pf_checker_props (
	input  logic clk,
	input  logic arst_n_i,
	input  logic pio_hvalid_i, pio_dvalid_i, pio_sop_i,
	input  logic afu_hvalid_i, afu_dvalid_i, afu_sop_i,
	input  logic def_hvalid_i, def_dvalid_i, def_sop_i,
	input  logic pio_ready_i,
	input  logic def_ready_i,
	input  logic rx_ready_i
);

	logic pio_act;
	logic afu_act;
	logic def_act;
	logic any_valid;

	assign pio_act   = pio_hvalid_i | pio_sop_i;
	assign afu_act   = afu_hvalid_i | afu_sop_i;
	assign def_act   = def_hvalid_i | def_sop_i;
	assign any_valid = pio_hvalid_i | pio_dvalid_i | afu_hvalid_i | afu_dvalid_i |
		def_hvalid_i | def_dvalid_i;

	one_egress_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0({pio_act, afu_act, def_act}))
		else $error("beat active on more than one egress");

	// ready is combinational, so it matches in every sampled cycle
	ready_and_a: assert property (@(posedge clk)
		rx_ready_i == (pio_ready_i & def_ready_i))
		else $error("rx ready differs from the AND of the egress readies");

	reset_idle_a: assert property (@(posedge clk) $rose(arst_n_i) |-> !any_valid)
		else $error("egress valid high right after reset release");

endmodule

bind pf_checker_top pf_checker_props u_props (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.pio_hvalid_i (pio_hvalid_o),
	.pio_dvalid_i (pio_dvalid_o),
	.pio_sop_i    (pio_sop_o),
	.afu_hvalid_i (afu_hvalid_o),
	.afu_dvalid_i (afu_dvalid_o),
	.afu_sop_i    (afu_sop_o),
	.def_hvalid_i (def_hvalid_o),
	.def_dvalid_i (def_dvalid_o),
	.def_sop_i    (def_sop_o),
	.pio_ready_i  (pio_ready_i),
	.def_ready_i  (def_ready_i),
	.rx_ready_i   (rx_ready_o)
);

// ==== src/pf_checker_top.sv ====
// ---------------------------------------------------------------------------
// PF checker top level
// routes rx beats to the PIO, AFU or default config egress, one cycle late
// ingress ready is the AND of the PIO and default config readies
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module pf_checker_top (
	input  logic                        clk,
	input  logic                        arst_n_i,

	// ingress
	input  logic                        rx_sop_i,
	input  logic                        rx_eop_i,
	input  logic                        rx_hvalid_i,
	input  logic                        rx_dvalid_i,
	input  pf_checker_pkg::bar_t        rx_bar_i,
	input  pf_checker_pkg::hdr_t        rx_header_i,
	input  pf_checker_pkg::payload_t    rx_payload_i,
	input  pf_checker_pkg::empty_t      rx_empty_i,
	input  pf_checker_pkg::pfnum_t      rx_pfnum_i,
	input  logic                        rx_passthrough_i,
	output logic                        rx_ready_o,

	// routing controls
	input  logic                        sel_afu_i,
	input  logic                        pf0_mem_en_i,
	input  logic                        pf1_mem_en_i,

	// PIO egress
	output logic                        pio_sop_o,
	output logic                        pio_eop_o,
	output logic                        pio_hvalid_o,
	output logic                        pio_dvalid_o,
	output pf_checker_pkg::bar_t        pio_bar_o,
	output pf_checker_pkg::hdr_t        pio_header_o,
	output pf_checker_pkg::payload_t    pio_payload_o,
	output pf_checker_pkg::empty_t      pio_empty_o,
	output pf_checker_pkg::pfnum_t      pio_pfnum_o,
	output logic                        pio_passthrough_o,
	input  logic                        pio_ready_i,

	// AFU egress
	output logic                        afu_sop_o,
	output logic                        afu_eop_o,
	output logic                        afu_hvalid_o,
	output logic                        afu_dvalid_o,
	output pf_checker_pkg::bar_t        afu_bar_o,
	output pf_checker_pkg::hdr_t        afu_header_o,
	output pf_checker_pkg::payload_t    afu_payload_o,
	output pf_checker_pkg::empty_t      afu_empty_o,
	output pf_checker_pkg::pfnum_t      afu_pfnum_o,
	output logic                        afu_passthrough_o,

	// default config egress
	output logic                        def_sop_o,
	output logic                        def_eop_o,
	output logic                        def_hvalid_o,
	output logic                        def_dvalid_o,
	output pf_checker_pkg::bar_t        def_bar_o,
	output pf_checker_pkg::hdr_t        def_header_o,
	output pf_checker_pkg::payload_t    def_payload_o,
	output pf_checker_pkg::empty_t      def_empty_o,
	output pf_checker_pkg::pfnum_t      def_pfnum_o,
	output logic                        def_passthrough_o,
	input  logic                        def_ready_i
);

	rx_st_if ing_st ();
	rx_st_if pio_st ();
	rx_st_if afu_st ();
	rx_st_if def_st ();

	pf_checker_pkg::dest_t dest;

	// ------------------------------------------------------------------------
	// ingress bundle
	// ------------------------------------------------------------------------
	assign ing_st.sop         = rx_sop_i;
	assign ing_st.eop         = rx_eop_i;
	assign ing_st.hvalid      = rx_hvalid_i;
	assign ing_st.dvalid      = rx_dvalid_i;
	assign ing_st.bar         = rx_bar_i;
	assign ing_st.header      = rx_header_i;
	assign ing_st.payload     = rx_payload_i;
	assign ing_st.empty       = rx_empty_i;
	assign ing_st.pfnum       = rx_pfnum_i;
	assign ing_st.passthrough = rx_passthrough_i;

	// no buffering, the source holds off while either sink is busy
	assign rx_ready_o = pio_ready_i & def_ready_i;

	// ------------------------------------------------------------------------
	// decode and egress stages
	// ------------------------------------------------------------------------
	tlp_route_decode u_decode (
		.rx           (ing_st),
		.sel_afu_i    (sel_afu_i),
		.pf0_mem_en_i (pf0_mem_en_i),
		.pf1_mem_en_i (pf1_mem_en_i),
		.dest_o       (dest)
	);

	rx_st_egress_reg #(.MY_DEST(pf_checker_pkg::DEST_PIO)) u_pio_reg (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.in       (ing_st),
		.dest_i   (dest),
		.out      (pio_st)
	);

	rx_st_egress_reg #(.MY_DEST(pf_checker_pkg::DEST_AFU)) u_afu_reg (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.in       (ing_st),
		.dest_i   (dest),
		.out      (afu_st)
	);

	rx_st_egress_reg #(.MY_DEST(pf_checker_pkg::DEST_DEF)) u_def_reg (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.in       (ing_st),
		.dest_i   (dest),
		.out      (def_st)
	);

	// ------------------------------------------------------------------------
	// egress ports
	// ------------------------------------------------------------------------
	assign pio_sop_o         = pio_st.sop;
	assign pio_eop_o         = pio_st.eop;
	assign pio_hvalid_o      = pio_st.hvalid;
	assign pio_dvalid_o      = pio_st.dvalid;
	assign pio_bar_o         = pio_st.bar;
	assign pio_header_o      = pio_st.header;
	assign pio_payload_o     = pio_st.payload;
	assign pio_empty_o       = pio_st.empty;
	assign pio_pfnum_o       = pio_st.pfnum;
	assign pio_passthrough_o = pio_st.passthrough;

	assign afu_sop_o         = afu_st.sop;
	assign afu_eop_o         = afu_st.eop;
	assign afu_hvalid_o      = afu_st.hvalid;
	assign afu_dvalid_o      = afu_st.dvalid;
	assign afu_bar_o         = afu_st.bar;
	assign afu_header_o      = afu_st.header;
	assign afu_payload_o     = afu_st.payload;
	assign afu_empty_o       = afu_st.empty;
	assign afu_pfnum_o       = afu_st.pfnum;
	assign afu_passthrough_o = afu_st.passthrough;

	assign def_sop_o         = def_st.sop;
	assign def_eop_o         = def_st.eop;
	assign def_hvalid_o      = def_st.hvalid;
	assign def_dvalid_o      = def_st.dvalid;
	assign def_bar_o         = def_st.bar;
	assign def_header_o      = def_st.header;
	assign def_payload_o     = def_st.payload;
	assign def_empty_o       = def_st.empty;
	assign def_pfnum_o       = def_st.pfnum;
	assign def_passthrough_o = def_st.passthrough;

endmodule

// ==== src/rx_st_egress_reg.sv ====
// ---------------------------------------------------------------------------
// egress register stage
// forwards the beat when routed here, otherwise drives all-zero fields
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module rx_st_egress_reg #(
	parameter pf_checker_pkg::dest_t MY_DEST = pf_checker_pkg::DEST_NONE
) (
	input  logic                    clk,
	input  logic                    arst_n_i,
	rx_st_if.dst                    in,
	input  pf_checker_pkg::dest_t   dest_i,
	rx_st_if.src                    out
);

	logic hit;

	assign hit = (dest_i == MY_DEST);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			out.sop         <= 1'b0;
			out.eop         <= 1'b0;
			out.hvalid      <= 1'b0;
			out.dvalid      <= 1'b0;
			out.bar         <= '0;
			out.header      <= '0;
			out.payload     <= '0;
			out.empty       <= '0;
			out.pfnum       <= '0;
			out.passthrough <= 1'b0;
		end
		else
		begin
			// a beat routed elsewhere shows up here as an idle cycle
			out.sop         <= hit ? in.sop         : 1'b0;
			out.eop         <= hit ? in.eop         : 1'b0;
			out.hvalid      <= hit ? in.hvalid      : 1'b0;
			out.dvalid      <= hit ? in.dvalid      : 1'b0;
			out.bar         <= hit ? in.bar         : '0;
			out.header      <= hit ? in.header      : '0;
			out.payload     <= hit ? in.payload     : '0;
			out.empty       <= hit ? in.empty       : '0;
			out.pfnum       <= hit ? in.pfnum       : '0;
			out.passthrough <= hit ? in.passthrough : 1'b0;
		end
	end

endmodule

// ==== src/tlp_route_decode.sv ====
// ---------------------------------------------------------------------------
// TLP class decode and routing decision
// classifies the format/type byte and picks one egress per beat
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module tlp_route_decode (
	rx_st_if.dst                    rx,
	input  logic                    sel_afu_i,
	input  logic                    pf0_mem_en_i,
	input  logic                    pf1_mem_en_i,
	output pf_checker_pkg::dest_t   dest_o
);

	pf_checker_pkg::fmt_type_t fmt_type;
	logic [2:0] fmt;
	logic [4:0] tlp_type;
	logic       is_cpl;
	logic       is_cpld;
	logic       is_mem_rd;
	logic       is_mem_wr;
	logic       any_cpl;
	logic       to_def;

	// ------------------------------------------------------------------------
	// header class
	// ------------------------------------------------------------------------
	assign fmt_type = rx.header[31:24];
	assign fmt      = fmt_type[7:5];
	assign tlp_type = fmt_type[4:0];

	assign is_cpl  = (fmt_type == pf_checker_pkg::FMT_TYPE_CPL);
	assign is_cpld = (fmt_type == pf_checker_pkg::FMT_TYPE_CPLD);
	assign any_cpl = is_cpl | is_cpld;

	assign is_mem_rd = (tlp_type == pf_checker_pkg::MEM_TYPE) &&
		(fmt == pf_checker_pkg::FMT_MEM_RD[0] || fmt == pf_checker_pkg::FMT_MEM_RD[1]);
	assign is_mem_wr = (tlp_type == pf_checker_pkg::MEM_TYPE) &&
		(fmt == pf_checker_pkg::FMT_MEM_WR[0] || fmt == pf_checker_pkg::FMT_MEM_WR[1]);

	// default config catches passthrough, memory requests on the AFU side
	// and anything whose PF has memory access disabled
	assign to_def = (rx.passthrough && !(any_cpl && sel_afu_i)) ||
		(sel_afu_i && (is_mem_rd || is_mem_wr)) ||
		(sel_afu_i && !pf0_mem_en_i) ||
		(!sel_afu_i && !pf1_mem_en_i);

	// ------------------------------------------------------------------------
	// ordered rules, so at most one egress is chosen
	// ------------------------------------------------------------------------
	always_comb
	begin
		if (!rx.passthrough && !sel_afu_i && pf1_mem_en_i)
			dest_o = pf_checker_pkg::DEST_PIO;
		else if (any_cpl && sel_afu_i && pf0_mem_en_i)
			dest_o = pf_checker_pkg::DEST_AFU;
		else if (to_def)
			dest_o = pf_checker_pkg::DEST_DEF;
		else
			dest_o = pf_checker_pkg::DEST_NONE;
	end

endmodule

// ==== src/rx_st_if.sv ====
// ---------------------------------------------------------------------------
// rx streaming beat bundle with source and sink modports
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

interface rx_st_if;

	logic                       sop;
	logic                       eop;
	logic                       hvalid;
	logic                       dvalid;
	pf_checker_pkg::bar_t       bar;
	pf_checker_pkg::hdr_t       header;
	pf_checker_pkg::payload_t   payload;
	pf_checker_pkg::empty_t     empty;
	pf_checker_pkg::pfnum_t     pfnum;
	// beat bypasses the PIO and targets default config
	logic                       passthrough;

	// side that presents the beat
	modport src (
		output sop, eop, hvalid, dvalid, bar, header,
		output payload, empty, pfnum, passthrough
	);

	// side that consumes the beat
	modport dst (
		input sop, eop, hvalid, dvalid, bar, header,
		input payload, empty, pfnum, passthrough
	);

endinterface

// ==== src/pf_checker_pkg.sv ====
// ---------------------------------------------------------------------------
// shared definitions for the PCIe rx stream router
// field widths and typedefs, format/type codes of the TLP header byte,
// and the destination codes used between decoder and egress stages
// ---------------------------------------------------------------------------

package pf_checker_pkg;

	// field widths of one streaming beat
	localparam int HDR_W      = 128;
	localparam int PAYLOAD_W  = 256;
	localparam int BAR_W      = 3;
	localparam int EMPTY_W    = 3;
	localparam int PFNUM_W    = 2;
	localparam int FMT_TYPE_W = 8;

	typedef logic [HDR_W-1:0]      hdr_t;
	typedef logic [PAYLOAD_W-1:0]  payload_t;
	typedef logic [BAR_W-1:0]      bar_t;
	typedef logic [EMPTY_W-1:0]    empty_t;
	typedef logic [PFNUM_W-1:0]    pfnum_t;

	// format/type byte, header bits 31 to 24
	typedef logic [FMT_TYPE_W-1:0] fmt_type_t;

	// ------------------------------------------------------------------------
	// format/type codes
	// ------------------------------------------------------------------------
	localparam fmt_type_t FMT_TYPE_CPL  = 8'h0A;
	localparam fmt_type_t FMT_TYPE_CPLD = 8'h4A;

	// type field of memory requests
	localparam logic [4:0] MEM_TYPE = 5'h00;

	// fmt patterns, 3DW and 4DW header forms
	localparam logic [1:0][2:0] FMT_MEM_RD = {3'b001, 3'b000};
	localparam logic [1:0][2:0] FMT_MEM_WR = {3'b011, 3'b010};

	// ------------------------------------------------------------------------
	// routing destination
	// ------------------------------------------------------------------------
	localparam int DEST_W = 2;

	typedef logic [DEST_W-1:0] dest_t;

	localparam dest_t DEST_NONE = 2'd0;
	localparam dest_t DEST_PIO  = 2'd1;
	localparam dest_t DEST_AFU  = 2'd2;
	localparam dest_t DEST_DEF  = 2'd3;

endpackage
